// ==== Makefile ====
VERILATOR ?= verilator
TOP       := trap_unit_tb
FILELIST  := trap_unit.f
VFLAGS    := --binary --timing --timescale 1ns/1ps -Wno-fatal
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(wildcard verilog/*.sv) $(wildcard tests/*.sv) $(wildcard tests/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The log decides pass or fail
run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tests/trap_unit_tasks.svh ====
`ifndef TRAP_UNIT_TASKS_SVH
`define TRAP_UNIT_TASKS_SVH

// ----------------------------------------------------------------------
// Helpers
// ----------------------------------------------------------------------

// Plain-words failure, ends the run
task automatic stop_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1, "run stopped");
endtask

// Compare, stop at the first mismatch
task automatic check_value(input string name, input logic [XLEN-1:0] actual,
                           input logic [XLEN-1:0] expected);
    if (actual !== expected) begin
        error_count++;
        $display("Fail at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
        $display("sim failed");
        $fatal(1, "stopped at the first mismatch");
    end
endtask

// One clock, then drive point after the edge
task automatic next_cycle();
    @(posedge clk);
    #2;
endtask

function automatic logic [XLEN-1:0] random_word();
    return {$urandom, $urandom};
endfunction

// Write lands on the next edge
task automatic csr_write(input logic [11:0] addr, input logic [XLEN-1:0] data);
    csr_wen   = 1'b1;
    csr_addr  = addr;
    csr_wdata = data;
    next_cycle();
    csr_wen   = 1'b0;
endtask

// Read is combinational, settle then compare
task automatic csr_expect(input logic [11:0] addr, input string name,
                          input logic [XLEN-1:0] expected);
    csr_addr = addr;
    #1;
    check_value(name, csr_rdata, expected);
endtask

task automatic mstatus_expect(input logic mie, input logic mpie, input logic [1:0] mpp);
    csr_addr = CSR_MSTATUS;
    #1;
    check_value("mstatus.MIE", XLEN'(csr_rdata[3]), XLEN'(mie));
    check_value("mstatus.MPIE", XLEN'(csr_rdata[7]), XLEN'(mpie));
    check_value("mstatus.MPP", XLEN'(csr_rdata[12:11]), XLEN'(mpp));
endtask

task automatic timecmp_write(input logic [XLEN-1:0] data);
    timecmp_wen   = 1'b1;
    timecmp_wdata = data;
    next_cycle();
    timecmp_wen   = 1'b0;
endtask

// Event at edge k, busy at k, redirect only between k+1 and k+2
task automatic run_event(input logic is_ecall, input logic [XLEN-1:0] at_pc,
                         input logic [XLEN-1:0] target);
    ecall = is_ecall;
    mret  = !is_ecall;
    pc    = at_pc;
    next_cycle();
    ecall = 1'b0;
    mret  = 1'b0;
    // Commit cycle
    check_value("busy", XLEN'(busy), XLEN'(1));
    check_value("redirect", XLEN'(redirect), '0);
    next_cycle();
    check_value("redirect", XLEN'(redirect), XLEN'(1));
    check_value("busy", XLEN'(busy), XLEN'(1));
    check_value("redirect_pc", redirect_pc, target);
    next_cycle();
    check_value("redirect", XLEN'(redirect), '0);
    check_value("busy", XLEN'(busy), '0);
endtask

// Bounded wait for a redirect
task automatic wait_redirect(input int max_cycles);
    int n;
    n = 0;
    while (redirect !== 1'b1) begin
        if (n >= max_cycles) begin
            stop_run("No redirect arrived after the timer interrupt was enabled");
        end
        next_cycle();
        n++;
    end
endtask

// ----------------------------------------------------------------------
// Directed tests
// ----------------------------------------------------------------------

task automatic test_reset_state();
    check_value("mtime", mtime, '0);
    check_value("redirect", XLEN'(redirect), '0);
    check_value("busy", XLEN'(busy), '0);
    csr_expect(CSR_MSTATUS, "mstatus", MSTATUS_RESET);
    csr_expect(CSR_MIE, "mie", '0);
    csr_expect(CSR_MTVEC, "mtvec", '0);
    csr_expect(CSR_MEPC, "mepc", '0);
    csr_expect(CSR_MCAUSE, "mcause", '0);
    csr_expect(CSR_MIP, "mip", '0);
endtask

task automatic test_csr_rw();
    logic [XLEN-1:0] value;
    value = random_word();
    csr_write(CSR_MSTATUS, value);
    csr_expect(CSR_MSTATUS, "mstatus", value);
    value = random_word();
    csr_write(CSR_MIE, value);
    csr_expect(CSR_MIE, "mie", value);
    // Low two bits forced to 0
    value = random_word();
    csr_write(CSR_MEPC, value);
    csr_expect(CSR_MEPC, "mepc", {value[XLEN-1:2], 2'b00});
    value = random_word();
    csr_write(CSR_MTVEC, value);
    csr_expect(CSR_MTVEC, "mtvec", {value[XLEN-1:2], 2'b00});
    // Aligned cause word
    value = random_word();
    value[1:0] = 2'b00;
    csr_write(CSR_MCAUSE, value);
    csr_expect(CSR_MCAUSE, "mcause", value);
    // mip is read only
    csr_write(CSR_MIP, random_word());
    csr_expect(CSR_MIP, "mip", '0);
    csr_write(12'h7c0, random_word());
    csr_expect(12'h7c0, "unmapped csr", '0);
    // Back to a quiet state
    csr_write(CSR_MSTATUS, MSTATUS_RESET);
    csr_write(CSR_MIE, '0);
endtask

task automatic test_ecall_entry();
    logic [XLEN-1:0] value;
    logic [XLEN-1:0] at_pc;
    value     = random_word();
    exp_mtvec = {value[XLEN-1:2], 2'b00};
    csr_write(CSR_MTVEC, value);
    // MIE on, MPIE off
    csr_write(CSR_MSTATUS, MSTATUS_RESET | XLEN'(8));
    at_pc = random_word();
    run_event(1'b1, at_pc, exp_mtvec);
    csr_expect(CSR_MEPC, "mepc", {at_pc[XLEN-1:2], 2'b00});
    csr_expect(CSR_MCAUSE, "mcause", CAUSE_ECALL_M);
    mstatus_expect(1'b0, 1'b1, 2'b11);
endtask

task automatic test_mret();
    logic [XLEN-1:0] value;
    value = random_word();
    csr_write(CSR_MEPC, value);
    run_event(1'b0, random_word(), {value[XLEN-1:2], 2'b00});
    mstatus_expect(1'b1, 1'b1, 2'b11);
    // Return leaves mepc and mcause alone
    csr_expect(CSR_MEPC, "mepc", {value[XLEN-1:2], 2'b00});
    csr_expect(CSR_MCAUSE, "mcause", CAUSE_ECALL_M);
endtask

task automatic test_timer_irq();
    logic [XLEN-1:0] t1;
    logic [XLEN-1:0] at_pc;
    int              n;
    // Line up on an mtime step
    t1 = mtime;
    n  = 0;
    while (mtime == t1) begin
        if (n > TICK_DIV) begin
            stop_run("mtime did not advance within one prescaler period");
        end
        next_cycle();
        n++;
    end
    t1 = mtime;
    repeat (TICK_DIV - 1) next_cycle();
    check_value("mtime", mtime, t1);
    next_cycle();
    check_value("mtime", mtime, t1 + XLEN'(1));

    // MTIE on, global MIE off
    csr_write(CSR_MSTATUS, MSTATUS_RESET);
    csr_write(CSR_MIE, XLEN'(1) << MIE_MTIE_BIT);
    timecmp_write(mtime + XLEN'(5));
    csr_addr = CSR_MIP;
    #1;
    n = 0;
    while (csr_rdata[MIP_MTIP_BIT] !== 1'b1) begin
        if (n > 8 * TICK_DIV) begin
            stop_run("mip timer bit never set after the mtimecmp write");
        end
        check_value("redirect", XLEN'(redirect), '0);
        next_cycle();
        n++;
    end
    // Pending but gated
    repeat (4) begin
        check_value("redirect", XLEN'(redirect), '0);
        check_value("busy", XLEN'(busy), '0);
        next_cycle();
    end
    csr_expect(CSR_MIP, "mip", XLEN'(1) << MIP_MTIP_BIT);

    // Resume pc held while the interrupt is taken
    at_pc = random_word();
    pc    = at_pc;
    csr_write(CSR_MSTATUS, MSTATUS_RESET | XLEN'(8));
    wait_redirect(4);
    check_value("redirect_pc", redirect_pc, exp_mtvec);
    next_cycle();
    check_value("busy", XLEN'(busy), '0);
    csr_expect(CSR_MCAUSE, "mcause", CAUSE_M_TIMER);
    csr_expect(CSR_MEPC, "mepc", {at_pc[XLEN-1:2], 2'b00});
endtask

task automatic test_priority();
    logic [XLEN-1:0] at_pc;
    // Timer still pending and enabled, MIE was cleared by the entry
    csr_write(CSR_MCAUSE, '0);
    csr_write(CSR_MSTATUS, MSTATUS_RESET | XLEN'(8));
    // irq_pending rises now, ecall lands in the same idle cycle
    at_pc = random_word();
    run_event(1'b1, at_pc, exp_mtvec);
    csr_expect(CSR_MCAUSE, "mcause", CAUSE_M_TIMER);
    csr_expect(CSR_MEPC, "mepc", {at_pc[XLEN-1:2], 2'b00});
    timecmp_write('1);
endtask

`endif

// ==== tests/trap_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module trap_unit_tb;
    import trap_pkg::*;

    localparam int TICK_DIV       = TICK_DIV_DEFAULT;
    // Tests need under a hundred cycles, this leaves a wide margin
    localparam int TIMEOUT_CYCLES = 2000;

    logic            clk;
    logic            reset;
    logic            csr_wen;
    logic [11:0]     csr_addr;
    logic [XLEN-1:0] csr_wdata;
    logic [XLEN-1:0] csr_rdata;
    logic            ecall;
    logic            mret;
    logic [XLEN-1:0] pc;
    logic            redirect;
    logic [XLEN-1:0] redirect_pc;
    logic            busy;
    logic            timecmp_wen;
    logic [XLEN-1:0] timecmp_wdata;
    logic [XLEN-1:0] mtime;

    // mtvec as last written, target of every trap entry
    logic [XLEN-1:0] exp_mtvec;
    int              error_count = 0;
    int              cycle_count = 0;

    trap_unit #(
        .TICK_DIV (TICK_DIV)
    ) uut (
        .clk           (clk),
        .reset         (reset),
        .csr_wen       (csr_wen),
        .csr_addr      (csr_addr),
        .csr_wdata     (csr_wdata),
        .csr_rdata     (csr_rdata),
        .ecall         (ecall),
        .mret          (mret),
        .pc            (pc),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .busy          (busy),
        .timecmp_wen   (timecmp_wen),
        .timecmp_wdata (timecmp_wdata),
        .mtime         (mtime)
    );

    `include "trap_unit_tasks.svh"

    // 40 ns clock
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_run("Timeout, the tests did not finish within the cycle limit");
        end
    end

    // ----------------------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------------------
    initial begin
        void'($urandom(32'h35ac0930));
        reset         = 1'b1;
        csr_wen       = 1'b0;
        csr_addr      = '0;
        csr_wdata     = '0;
        ecall         = 1'b0;
        mret          = 1'b0;
        pc            = '0;
        timecmp_wen   = 1'b0;
        timecmp_wdata = '0;
        exp_mtvec     = '0;
        repeat (16) next_cycle();
        reset = 1'b0;

        test_reset_state();
        test_csr_rw();
        test_ecall_entry();
        test_mret();
        test_timer_irq();
        test_priority();

        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== trap_unit.f ====
+incdir+tests
verilog/trap_pkg.sv
verilog/csr_file.sv
verilog/machine_timer.sv
verilog/trap_fsm.sv
verilog/trap_unit.sv
tests/trap_unit_tb.sv

// ==== verilog/csr_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_file (
    input  logic                      clk,
    input  logic                      reset,
    // Core CSR port
    input  logic                      csr_wen,
    input  logic [11:0]               csr_addr,
    input  logic [trap_pkg::XLEN-1:0] csr_wdata,
    output logic [trap_pkg::XLEN-1:0] csr_rdata,
    // Trap update port
    input  logic [1:0]                trap_wen,
    input  logic [trap_pkg::XLEN-1:0] trap_mepc,
    input  logic [trap_pkg::XLEN-1:0] trap_mcause,
    input  trap_pkg::mstatus_u        trap_mstatus,
    // Timer
    input  logic                      timer_pending,
    // State seen by the trap FSM
    output trap_pkg::mstatus_u        mstatus_q,
    output logic [trap_pkg::XLEN-1:0] mtvec_q,
    output logic [trap_pkg::XLEN-1:0] mepc_q,
    output logic                      irq_pending
);
    import trap_pkg::*;

    logic [XLEN-1:0] mie_q;
    logic [XLEN-1:0] mcause_q;
    // Only MTIP is implemented in mip
    logic            mtip_q;
    logic [XLEN-1:0] mip_word;

    // Core write decode
    logic wr_mstatus;
    logic wr_mie;
    logic wr_mtvec;
    logic wr_mepc;
    logic wr_mcause;

    assign wr_mstatus = csr_wen && (csr_addr == CSR_MSTATUS);
    assign wr_mie     = csr_wen && (csr_addr == CSR_MIE);
    assign wr_mtvec   = csr_wen && (csr_addr == CSR_MTVEC);
    assign wr_mepc    = csr_wen && (csr_addr == CSR_MEPC);
    assign wr_mcause  = csr_wen && (csr_addr == CSR_MCAUSE);

    // ----------------------------------------------------------------------
    // Registers, trap port wins over the core port
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            mstatus_q.raw <= MSTATUS_RESET;
            mie_q         <= '0;
            mtvec_q       <= '0;
            mepc_q        <= '0;
            mcause_q      <= '0;
            mtip_q        <= 1'b0;
        end else begin
            if (trap_wen[WEN_MSTATUS]) begin
                mstatus_q <= trap_mstatus;
            end else if (wr_mstatus) begin
                mstatus_q.raw <= csr_wdata;
            end
            if (wr_mie) begin
                mie_q <= csr_wdata;
            end
            // Direct mode only, base is word aligned
            if (wr_mtvec) begin
                mtvec_q <= {csr_wdata[XLEN-1:2], 2'b00};
            end
            if (trap_wen[WEN_ENTRY]) begin
                mepc_q   <= {trap_mepc[XLEN-1:2], 2'b00};
                mcause_q <= trap_mcause;
            end else begin
                if (wr_mepc) begin
                    mepc_q <= {csr_wdata[XLEN-1:2], 2'b00};
                end
                if (wr_mcause) begin
                    mcause_q <= csr_wdata;
                end
            end
            // mip is read only, follows the timer
            mtip_q <= timer_pending;
        end
    end

    // mip as the core sees it
    always_comb begin
        mip_word               = '0;
        mip_word[MIP_MTIP_BIT] = mtip_q;
    end

    // Read mux, unmapped addresses give 0
    always_comb begin
        case (csr_addr)
            CSR_MSTATUS: csr_rdata = mstatus_q.raw;
            CSR_MIE:     csr_rdata = mie_q;
            CSR_MTVEC:   csr_rdata = mtvec_q;
            CSR_MEPC:    csr_rdata = mepc_q;
            CSR_MCAUSE:  csr_rdata = mcause_q;
            CSR_MIP:     csr_rdata = mip_word;
            default:     csr_rdata = '0;
        endcase
    end

    // Global enable, timer enable, timer pending
    assign irq_pending = mstatus_q.f.mie & mie_q[MIE_MTIE_BIT] & mtip_q;

endmodule

`default_nettype wire

// ==== verilog/machine_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module machine_timer #(
    parameter int TICK_DIV = trap_pkg::TICK_DIV_DEFAULT
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      timecmp_wen,
    input  logic [trap_pkg::XLEN-1:0] timecmp_wdata,
    output logic [trap_pkg::XLEN-1:0] mtime,
    output logic                      timer_pending
);
    import trap_pkg::*;

    // Prescaler width, at least one bit
    localparam int DIV_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(TICK_DIV - 1);

    logic [DIV_W-1:0] div_cnt;
    logic             tick;
    logic [XLEN-1:0]  mtimecmp;

    // ----------------------------------------------------------------------
    // Prescaler and mtime
    // ----------------------------------------------------------------------
    assign tick = (div_cnt == DIV_LAST);

    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt <= '0;
            mtime   <= '0;
        end else if (tick) begin
            div_cnt <= '0;
            mtime   <= mtime + XLEN'(1);
        end else begin
            div_cnt <= div_cnt + DIV_W'(1);
        end
    end

    // Compare register, all ones keeps the interrupt quiet
    always_ff @(posedge clk) begin
        if (reset) begin
            mtimecmp <= '1;
        end else if (timecmp_wen) begin
            mtimecmp <= timecmp_wdata;
        end
    end

    // Unsigned compare
    assign timer_pending = (mtime >= mtimecmp);

endmodule

`default_nettype wire

// ==== verilog/trap_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module trap_fsm (
    input  logic                      clk,
    input  logic                      reset,
    // Events from the core
    input  logic                      ecall,
    input  logic                      mret,
    input  logic [trap_pkg::XLEN-1:0] pc,
    // CSR state
    input  logic                      irq_pending,
    input  trap_pkg::mstatus_u        mstatus_q,
    input  logic [trap_pkg::XLEN-1:0] mtvec_q,
    input  logic [trap_pkg::XLEN-1:0] mepc_q,
    // Trap update port
    output logic [1:0]                trap_wen,
    output logic [trap_pkg::XLEN-1:0] trap_mepc,
    output logic [trap_pkg::XLEN-1:0] trap_mcause,
    output trap_pkg::mstatus_u        trap_mstatus,
    // Back to the core
    output logic                      redirect,
    output logic [trap_pkg::XLEN-1:0] redirect_pc,
    output logic                      busy
);
    import trap_pkg::*;

    localparam logic [1:0] ST_IDLE     = 2'd0;
    localparam logic [1:0] ST_COMMIT   = 2'd1;
    localparam logic [1:0] ST_REDIRECT = 2'd2;

    localparam logic [1:0] KIND_IRQ   = 2'd0;
    localparam logic [1:0] KIND_ECALL = 2'd1;
    localparam logic [1:0] KIND_MRET  = 2'd2;

    logic [1:0]      state;
    logic [1:0]      kind_q;
    logic [XLEN-1:0] pc_q;
    logic            start;
    logic            is_mret;

    // Any event accepted only in idle
    assign start   = (state == ST_IDLE) && (irq_pending || ecall || mret);
    assign is_mret = (kind_q == KIND_MRET);

    // ----------------------------------------------------------------------
    // State and event latch
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= ST_IDLE;
            kind_q <= KIND_IRQ;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state <= ST_COMMIT;
                        // Interrupt first, then ecall, then mret
                        if (irq_pending) begin
                            kind_q <= KIND_IRQ;
                        end else if (ecall) begin
                            kind_q <= KIND_ECALL;
                        end else begin
                            kind_q <= KIND_MRET;
                        end
                    end
                end
                ST_COMMIT:   state <= ST_REDIRECT;
                default:     state <= ST_IDLE;
            endcase
        end
    end

    // Faulting or resume pc
    always_ff @(posedge clk) begin
        if (start) begin
            pc_q <= pc;
        end
    end

    // ----------------------------------------------------------------------
    // CSR update values
    // ----------------------------------------------------------------------
    always_comb begin
        trap_mstatus = mstatus_q;
        if (is_mret) begin
            trap_mstatus.f.mie  = mstatus_q.f.mpie;
            trap_mstatus.f.mpie = 1'b1;
        end else begin
            // Stack MIE and stay in M-mode
            trap_mstatus.f.mpie = mstatus_q.f.mie;
            trap_mstatus.f.mie  = 1'b0;
            trap_mstatus.f.mpp  = 2'b11;
        end
    end

    assign trap_mepc   = pc_q;
    assign trap_mcause = (kind_q == KIND_IRQ) ? CAUSE_M_TIMER : CAUSE_ECALL_M;

    // mstatus always, mepc/mcause on entry only
    assign trap_wen[WEN_MSTATUS] = (state == ST_COMMIT);
    assign trap_wen[WEN_ENTRY]   = (state == ST_COMMIT) && !is_mret;

    // Target read after the commit edge
    assign redirect    = (state == ST_REDIRECT);
    assign redirect_pc = is_mret ? mepc_q : mtvec_q;
    assign busy        = (state != ST_IDLE);

endmodule

`default_nettype wire

// ==== verilog/trap_pkg.sv ====
`default_nettype none

package trap_pkg;

    // Register width of the core
    localparam int XLEN = 64;

    // ----------------------------------------------------------------------
    // Machine CSR addresses
    // ----------------------------------------------------------------------
    localparam logic [11:0] CSR_MSTATUS = 12'h300;
    localparam logic [11:0] CSR_MIE     = 12'h304;
    localparam logic [11:0] CSR_MTVEC   = 12'h305;
    localparam logic [11:0] CSR_MEPC    = 12'h341;
    localparam logic [11:0] CSR_MCAUSE  = 12'h342;
    localparam logic [11:0] CSR_MIP     = 12'h344;

    // Cause codes, interrupt flag in the top bit
    localparam logic [XLEN-1:0] CAUSE_ECALL_M = XLEN'(11);
    localparam logic [XLEN-1:0] CAUSE_M_TIMER = (XLEN'(1) << (XLEN - 1)) | XLEN'(7);

    // UXL = SXL = 2, MPP = 3
    localparam logic [XLEN-1:0] MSTATUS_RESET = XLEN'(64'h0000_000A_0000_1800);

    // Timer enable / pending bit in mie and mip
    localparam int MIE_MTIE_BIT = 7;
    localparam int MIP_MTIP_BIT = 7;

    // Clocks per mtime tick
    localparam int TICK_DIV_DEFAULT = 4;

    // Bits of the trap-side write enable
    localparam int WEN_MSTATUS = 0;
    localparam int WEN_ENTRY   = 1;

    // mstatus, only the fields the trap logic touches are named
    typedef struct packed {
        logic [XLEN-14:0] rsv_hi;   // 63..13, incl. UXL/SXL
        logic [1:0]       mpp;      // 12..11
        logic [2:0]       rsv_mid;  // 10..8
        logic             mpie;     // 7
        logic [2:0]       rsv_lo;   // 6..4
        logic             mie;      // 3
        logic [2:0]       rsv_bot;  // 2..0
    } mstatus_fields_t;

    // Raw view for the core port, field view for the trap logic
    typedef union packed {
        logic [XLEN-1:0] raw;
        mstatus_fields_t f;
    } mstatus_u;

endpackage

`default_nettype wire

// ==== verilog/trap_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module trap_unit #(
    parameter int TICK_DIV = trap_pkg::TICK_DIV_DEFAULT
) (
    input  logic                      clk,
    input  logic                      reset,
    // CSR access
    input  logic                      csr_wen,
    input  logic [11:0]               csr_addr,
    input  logic [trap_pkg::XLEN-1:0] csr_wdata,
    output logic [trap_pkg::XLEN-1:0] csr_rdata,
    // Trap events
    input  logic                      ecall,
    input  logic                      mret,
    input  logic [trap_pkg::XLEN-1:0] pc,
    output logic                      redirect,
    output logic [trap_pkg::XLEN-1:0] redirect_pc,
    output logic                      busy,
    // Timer
    input  logic                      timecmp_wen,
    input  logic [trap_pkg::XLEN-1:0] timecmp_wdata,
    output logic [trap_pkg::XLEN-1:0] mtime
);
    import trap_pkg::*;

    logic            timer_pending;
    logic            irq_pending;
    mstatus_u        mstatus_q;
    logic [XLEN-1:0] mtvec_q;
    logic [XLEN-1:0] mepc_q;
    // Trap side CSR writes
    logic [1:0]      trap_wen;
    logic [XLEN-1:0] trap_mepc;
    logic [XLEN-1:0] trap_mcause;
    mstatus_u        trap_mstatus;

    csr_file u_csr_file (
        .clk           (clk),
        .reset         (reset),
        .csr_wen       (csr_wen),
        .csr_addr      (csr_addr),
        .csr_wdata     (csr_wdata),
        .csr_rdata     (csr_rdata),
        .trap_wen      (trap_wen),
        .trap_mepc     (trap_mepc),
        .trap_mcause   (trap_mcause),
        .trap_mstatus  (trap_mstatus),
        .timer_pending (timer_pending),
        .mstatus_q     (mstatus_q),
        .mtvec_q       (mtvec_q),
        .mepc_q        (mepc_q),
        .irq_pending   (irq_pending)
    );

    machine_timer #(
        .TICK_DIV (TICK_DIV)
    ) u_machine_timer (
        .clk           (clk),
        .reset         (reset),
        .timecmp_wen   (timecmp_wen),
        .timecmp_wdata (timecmp_wdata),
        .mtime         (mtime),
        .timer_pending (timer_pending)
    );

    trap_fsm u_trap_fsm (
        .clk          (clk),
        .reset        (reset),
        .ecall        (ecall),
        .mret         (mret),
        .pc           (pc),
        .irq_pending  (irq_pending),
        .mstatus_q    (mstatus_q),
        .mtvec_q      (mtvec_q),
        .mepc_q       (mepc_q),
        .trap_wen     (trap_wen),
        .trap_mepc    (trap_mepc),
        .trap_mcause  (trap_mcause),
        .trap_mstatus (trap_mstatus),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .busy         (busy)
    );

endmodule

`default_nettype wire
